// ==== design/mips_mem_pkg.sv ====
`default_nettype none

package mips_mem_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int PC_WIDTH       = 7;
    localparam int MEM_CTRL_WIDTH = 6;
    localparam int WB_CTRL_WIDTH  = 3;
    localparam int MEM_SIZE_WIDTH = 2;

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [PC_WIDTH-1:0]       pc_t;
    typedef logic [MEM_CTRL_WIDTH-1:0] mem_ctrl_t;
    typedef logic [WB_CTRL_WIDTH-1:0]  wb_ctrl_t;
    typedef logic [MEM_SIZE_WIDTH-1:0] mem_size_t;

    // memory control field, bit 0 is reserved.
    localparam int MEM_WRITE_BIT    = 5;
    localparam int MEM_READ_BIT     = 4;
    localparam int MEM_UNSIGNED_BIT = 3;
    localparam int MEM_SIZE_LSB     = 1;

    localparam int WB_REG_WRITE_BIT  = 2;
    localparam int WB_MEM_TO_REG_BIT = 1;
    localparam int WB_LINK_BIT       = 0;

    // size code 3 falls through to a word access.
    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    localparam int DMEM_WORDS       = 32;
    localparam int DMEM_ADDR_BITS   = 5;
    localparam int BYTE_OFFSET_BITS = 2;

endpackage

`default_nettype wire

// ==== design/ex_mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_mem_stage (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    en_pipeline_i,
    input  wire mips_mem_pkg::data_t     data_wr_to_mem_i,
    input  wire mips_mem_pkg::data_t     alu_result_i,
    input  wire mips_mem_pkg::reg_addr_t write_reg_i,
    input  wire mips_mem_pkg::pc_t       pc_i,
    input  wire mips_mem_pkg::mem_ctrl_t mem_signals_i,
    input  wire mips_mem_pkg::wb_ctrl_t  wb_signals_i,
    input  wire                    halt_signal_i,

    output mips_mem_pkg::data_t     data_wr_to_mem_o,
    output mips_mem_pkg::data_t     alu_result_o,
    output mips_mem_pkg::reg_addr_t write_reg_o,
    output mips_mem_pkg::pc_t       pc_o,
    output mips_mem_pkg::mem_ctrl_t mem_signals_o,
    output mips_mem_pkg::wb_ctrl_t  wb_signals_o,
    output logic                    halt_signal_o
);

    import mips_mem_pkg::*;

    // the whole stage moves on the falling edge, the rising half is setup time.
    always_ff @(negedge clock)
    begin
        if (reset)
        begin
            data_wr_to_mem_o <= '0;
            alu_result_o     <= '0;
            write_reg_o      <= '0;
            pc_o             <= '0;
            mem_signals_o    <= '0;  // no store leaves a cleared stage.
            wb_signals_o     <= '0;  // and no register write either.
            halt_signal_o    <= 1'b0;
        end
        else if (en_pipeline_i)
        begin
            data_wr_to_mem_o <= data_wr_to_mem_i;
            alu_result_o     <= alu_result_i;
            write_reg_o      <= write_reg_i;
            pc_o             <= pc_i;
            mem_signals_o    <= mem_signals_i;
            wb_signals_o     <= wb_signals_i;
            halt_signal_o    <= halt_signal_i;
        end
        // with the enable low everything simply holds.
    end

endmodule

`default_nettype wire

// ==== design/data_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_memory (
    input  wire                          clock,
    input  wire                          en_pipeline_i,
    input  wire mips_mem_pkg::mem_ctrl_t mem_signals_i,
    input  wire mips_mem_pkg::data_t     addr_i,
    input  wire mips_mem_pkg::data_t     wdata_i,
    output mips_mem_pkg::data_t          rdata_o
);

    import mips_mem_pkg::*;

    data_t mem [DMEM_WORDS];

    logic [DMEM_ADDR_BITS-1:0]   word_idx;
    logic [BYTE_OFFSET_BITS-1:0] byte_off;
    mem_size_t                   size;
    logic                        is_unsigned;
    logic [3:0]                  byte_en;
    data_t                       wdata_lanes;
    data_t                       rd_word;
    logic [7:0]                  rd_byte;
    logic [15:0]                 rd_half;
    data_t                       load_val;

    assign word_idx    = addr_i[BYTE_OFFSET_BITS +: DMEM_ADDR_BITS];
    assign byte_off    = addr_i[BYTE_OFFSET_BITS-1:0];
    assign size        = mem_signals_i[MEM_SIZE_LSB +: MEM_SIZE_WIDTH];
    assign is_unsigned = mem_signals_i[MEM_UNSIGNED_BIT];

    // stores put the small operand into every lane and let the byte enables pick.
    always_comb
    begin
        case (size)
            SIZE_BYTE:
            begin
                byte_en     = 4'b0001 << byte_off;
                wdata_lanes = {4{wdata_i[7:0]}};
            end
            SIZE_HALF:
            begin
                byte_en     = byte_off[1] ? 4'b1100 : 4'b0011;  // bit 0 is ignored.
                wdata_lanes = {2{wdata_i[15:0]}};
            end
            default:
            begin
                byte_en     = 4'b1111;
                wdata_lanes = wdata_i;
            end
        endcase
    end

    always_ff @(negedge clock)
    begin
        if (en_pipeline_i && mem_signals_i[MEM_WRITE_BIT])
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (byte_en[lane])
                    mem[word_idx][8*lane +: 8] <= wdata_lanes[8*lane +: 8];
            end
        end
    end

    assign rd_word = mem[word_idx];
    assign rd_byte = rd_word[{byte_off, 3'b000} +: 8];
    assign rd_half = byte_off[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb
    begin
        case (size)
            SIZE_BYTE:
                load_val = {{(DATA_WIDTH-8){rd_byte[7] & ~is_unsigned}}, rd_byte};
            SIZE_HALF:
                load_val = {{(DATA_WIDTH-16){rd_half[15] & ~is_unsigned}}, rd_half};
            default:
                load_val = rd_word;
        endcase
    end

    // the read port only shows data while a load is in the stage.
    assign rdata_o = mem_signals_i[MEM_READ_BIT] ? load_val : '0;

endmodule

`default_nettype wire

// ==== design/mem_wb_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          en_pipeline_i,
    input  wire mips_mem_pkg::data_t     mem_data_i,
    input  wire mips_mem_pkg::data_t     alu_result_i,
    input  wire mips_mem_pkg::pc_t       pc_i,
    input  wire mips_mem_pkg::reg_addr_t write_reg_i,
    input  wire mips_mem_pkg::wb_ctrl_t  wb_signals_i,
    input  wire                          halt_signal_i,

    output logic                         reg_write_o,
    output mips_mem_pkg::reg_addr_t      write_reg_o,
    output mips_mem_pkg::data_t          write_data_o,
    output logic                         halt_signal_o
);

    import mips_mem_pkg::*;

    data_t     mem_data_q;
    data_t     alu_result_q;
    pc_t       pc_q;
    wb_ctrl_t  wb_q;

    always_ff @(negedge clock)
    begin
        if (reset)
        begin
            mem_data_q    <= '0;
            alu_result_q  <= '0;
            pc_q          <= '0;
            write_reg_o   <= '0;
            wb_q          <= '0;
            halt_signal_o <= 1'b0;
        end
        else if (en_pipeline_i)
        begin
            mem_data_q    <= mem_data_i;
            alu_result_q  <= alu_result_i;
            pc_q          <= pc_i;
            write_reg_o   <= write_reg_i;
            wb_q          <= wb_signals_i;
            halt_signal_o <= halt_signal_i;
        end
    end

    // link wins over memory-to-register.
    always_comb
    begin
        if (wb_q[WB_LINK_BIT])
            write_data_o = {{(DATA_WIDTH-PC_WIDTH){1'b0}}, pc_q};
        else if (wb_q[WB_MEM_TO_REG_BIT])
            write_data_o = mem_data_q;
        else
            write_data_o = alu_result_q;
    end

    assign reg_write_o = wb_q[WB_REG_WRITE_BIT];

endmodule

`default_nettype wire

// ==== design/mem_wb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_wb_top (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          en_pipeline_i,
    input  wire mips_mem_pkg::data_t     data_wr_to_mem_i,
    input  wire mips_mem_pkg::data_t     alu_result_i,
    input  wire mips_mem_pkg::reg_addr_t write_reg_i,
    input  wire mips_mem_pkg::pc_t       pc_i,
    input  wire mips_mem_pkg::mem_ctrl_t mem_signals_i,
    input  wire mips_mem_pkg::wb_ctrl_t  wb_signals_i,
    input  wire                          halt_signal_i,

    output wire                          reg_write_o,
    output wire mips_mem_pkg::reg_addr_t write_reg_o,
    output wire mips_mem_pkg::data_t     write_data_o,
    output wire                          halt_signal_o
);

    import mips_mem_pkg::*;

    // memory stage signals, all straight out of the EX/MEM register.
    data_t     mem_store_data;
    data_t     mem_alu_result;
    reg_addr_t mem_write_reg;
    pc_t       mem_pc;
    mem_ctrl_t mem_ctrl;
    wb_ctrl_t  mem_wb_ctrl;
    logic      mem_halt;
    data_t     mem_load_data;

    ex_mem_stage ex_mem_stage_i (
        .clock            (clock),
        .reset            (reset),
        .en_pipeline_i    (en_pipeline_i),
        .data_wr_to_mem_i (data_wr_to_mem_i),
        .alu_result_i     (alu_result_i),
        .write_reg_i      (write_reg_i),
        .pc_i             (pc_i),
        .mem_signals_i    (mem_signals_i),
        .wb_signals_i     (wb_signals_i),
        .halt_signal_i    (halt_signal_i),
        .data_wr_to_mem_o (mem_store_data),
        .alu_result_o     (mem_alu_result),
        .write_reg_o      (mem_write_reg),
        .pc_o             (mem_pc),
        .mem_signals_o    (mem_ctrl),
        .wb_signals_o     (mem_wb_ctrl),
        .halt_signal_o    (mem_halt)
    );

    // the store lands on the same edge that moves the instruction into MEM/WB.
    data_memory data_memory_i (
        .clock         (clock),
        .en_pipeline_i (en_pipeline_i),
        .mem_signals_i (mem_ctrl),
        .addr_i        (mem_alu_result),
        .wdata_i       (mem_store_data),
        .rdata_o       (mem_load_data)
    );

    mem_wb_stage mem_wb_stage_i (
        .clock         (clock),
        .reset         (reset),
        .en_pipeline_i (en_pipeline_i),
        .mem_data_i    (mem_load_data),
        .alu_result_i  (mem_alu_result),
        .pc_i          (mem_pc),
        .write_reg_i   (mem_write_reg),
        .wb_signals_i  (mem_wb_ctrl),
        .halt_signal_i (mem_halt),
        .reg_write_o   (reg_write_o),
        .write_reg_o   (write_reg_o),
        .write_data_o  (write_data_o),
        .halt_signal_o (halt_signal_o)
    );

endmodule

`default_nettype wire

// ==== dv/mem_wb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_wb_checker (
    input wire                          clock,
    input wire                          reset,
    input wire                          en_pipeline_i,
    input wire                          halt_signal_i,
    input wire                          reg_write_o,
    input wire mips_mem_pkg::reg_addr_t write_reg_o,
    input wire mips_mem_pkg::data_t     write_data_o,
    input wire                          halt_signal_o
);

    logic        halt_in_mem;  // halt of the instruction now held in EX/MEM.
    int unsigned assert_failures = 0;

    always_ff @(negedge clock)
    begin
        if (reset)
            halt_in_mem <= 1'b0;
        else if (en_pipeline_i)
            halt_in_mem <= halt_signal_i;
    end

    reset_clears: assert property (@(negedge clock) reset |=> !reg_write_o && !halt_signal_o)
    else
    begin
        assert_failures++;
        $error("reset did not clear reg_write_o and halt_signal_o");
    end

    stall_holds: assert property (@(negedge clock) disable iff (reset)
        !en_pipeline_i |=> $stable({reg_write_o, write_reg_o, write_data_o, halt_signal_o}))
    else
    begin
        assert_failures++;
        $error("outputs changed while the pipeline was stalled");
    end

    // a rise must come from an enabled edge that moved a halted instruction out of EX/MEM.
    halt_latency: assert property (@(negedge clock) disable iff (reset)
        $rose(halt_signal_o) |-> $past(en_pipeline_i && halt_in_mem))
    else
    begin
        assert_failures++;
        $error("halt_signal_o rose without a halt two enabled edges earlier");
    end

endmodule

bind mem_wb_top mem_wb_checker mem_wb_checker_i (.*);

`default_nettype wire

// ==== dv/tb_mem_wb.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_wb;

    import mips_mem_pkg::*;

    localparam int RANDOM_STEPS = 600;
    localparam int WAIT_LIMIT   = 40;

    logic      clock            = 1'b0;
    logic      reset            = 1'b1;
    logic      en_pipeline_i    = 1'b0;
    data_t     data_wr_to_mem_i = '0;
    data_t     alu_result_i     = '0;
    reg_addr_t write_reg_i      = '0;
    pc_t       pc_i             = '0;
    mem_ctrl_t mem_signals_i    = '0;
    wb_ctrl_t  wb_signals_i     = '0;
    logic      halt_signal_i    = 1'b0;
    logic      reg_write_o;
    reg_addr_t write_reg_o;
    data_t     write_data_o;
    logic      halt_signal_o;

    // reference model. s1 is the instruction that sits in EX/MEM.
    data_t       model_mem [DMEM_WORDS];
    data_t       s1_store       = '0;
    data_t       s1_alu         = '0;
    reg_addr_t   s1_reg         = '0;
    pc_t         s1_pc          = '0;
    mem_ctrl_t   s1_mem         = '0;
    wb_ctrl_t    s1_wb          = '0;
    logic        s1_halt        = 1'b0;
    logic        exp_reg_write  = 1'b0;
    reg_addr_t   exp_write_reg  = '0;
    data_t       exp_write_data = '0;
    logic        exp_halt       = 1'b0;
    int          errors         = 0;
    logic [31:0] lcg_state      = 32'd23;

    mem_wb_top mem_wb_top_i (.*);

    always #5 clock = ~clock;

    initial
    begin
        repeat (8) @(posedge clock);
        reset <= 1'b0;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_outputs();
        check_value("reg_write_o", reg_write_o, exp_reg_write);
        check_value("write_reg_o", write_reg_o, exp_write_reg);
        check_value("write_data_o", write_data_o, exp_write_data);
        check_value("halt_signal_o", halt_signal_o, exp_halt);
    endtask

    // one enabled falling edge. s1 retires to the outputs and the driven inputs enter.
    task automatic advance_model();
        mem_size_t size;
        data_t     mask;
        data_t     loaded;
        int        sh;
        int        idx;
        size = s1_mem[MEM_SIZE_LSB +: MEM_SIZE_WIDTH];
        idx  = s1_alu[2 +: DMEM_ADDR_BITS];
        mask = (size == SIZE_BYTE) ? 32'h0000_00ff : (size == SIZE_HALF) ? 32'h0000_ffff : '1;
        sh   = (size == SIZE_BYTE) ? 8 * s1_alu[1:0] : (size == SIZE_HALF) ? 16 * s1_alu[1] : 0;
        loaded = (model_mem[idx] >> sh) & mask;
        if (!s1_mem[MEM_UNSIGNED_BIT] && (loaded & ~(mask >> 1)) != '0)
            loaded = loaded | ~mask;  // top bit of the field is set, so sign extend.
        if (s1_wb[WB_LINK_BIT])
            exp_write_data = data_t'(s1_pc);
        else if (s1_wb[WB_MEM_TO_REG_BIT])
            exp_write_data = loaded;
        else
            exp_write_data = s1_alu;
        exp_reg_write = s1_wb[WB_REG_WRITE_BIT];
        exp_write_reg = s1_reg;
        exp_halt      = s1_halt;
        // the store only touches its own lanes.
        if (s1_mem[MEM_WRITE_BIT])
            model_mem[idx] = (model_mem[idx] & ~(mask << sh)) | ((s1_store << sh) & (mask << sh));
        s1_store = data_wr_to_mem_i;
        s1_alu   = alu_result_i;
        s1_reg   = write_reg_i;
        s1_pc    = pc_i;
        s1_mem   = mem_signals_i;
        s1_wb    = wb_signals_i;
        s1_halt  = halt_signal_i;
    endtask

    always @(negedge clock)
    begin
        if (!reset && en_pipeline_i)
            advance_model();
    end

    task automatic step(logic en, data_t store, data_t alu, reg_addr_t rd, pc_t pc,
                        mem_ctrl_t mem, wb_ctrl_t wb, logic halt);
        @(posedge clock);
        compare_outputs();
        en_pipeline_i    <= en;
        data_wr_to_mem_i <= store;
        alu_result_i     <= alu;
        write_reg_i      <= rd;
        pc_i             <= pc;
        mem_signals_i    <= mem;
        wb_signals_i     <= wb;
        halt_signal_i    <= halt;
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] a;
        logic [1:0]  kind;
        mem_ctrl_t   mem;
        wb_ctrl_t    wb;
        data_t       alu;
        int          wait_cnt;
        wait_cnt = 0;
        while (reset && wait_cnt < WAIT_LIMIT)
        begin
            @(posedge clock);
            wait_cnt++;
        end
        if (reset)
        begin
            $display("timeout waiting for reset to be released");
            $display("SOME TESTS FAILED");
            $finish;
        end
        compare_outputs();
        // word stores to every location first, so no load ever reads an unwritten word.
        for (int i = 0; i < DMEM_WORDS; i++)
            step(1'b1, lcg_next(), data_t'(4 * i), '0, '0,
                 {1'b1, 1'b0, 1'b0, SIZE_WORD, 1'b0}, '0, 1'b0);
        repeat (RANDOM_STEPS)
        begin
            r    = lcg_next();
            a    = lcg_next();
            kind = r[17:16];  // store, load, alu, link.
            alu  = (kind < 2) ? {25'b0, a[31:25]} : a;
            mem  = (kind < 2) ? {kind == 0, kind == 1, r[18], r[20:19], r[21]} : '0;
            wb   = (kind == 0) ? 3'b000 : (kind == 1) ? 3'b110 :
                   (kind == 2) ? {r[22], 2'b00} : {1'b1, r[23], 1'b1};
            step(r[31:30] != 2'b00, lcg_next(), alu, a[15:11], a[22:16], mem, wb,
                 r[27:24] == 4'h0);
        end
        wait_cnt = 0;
        do
        begin
            step(1'b1, '0, '0, '0, '0, '0, '0, 1'b0);
            wait_cnt++;
        end
        while ((s1_mem != '0 || s1_wb != '0 || s1_halt || exp_reg_write || exp_halt)
               && wait_cnt < WAIT_LIMIT);
        if (wait_cnt >= WAIT_LIMIT)
        begin
            $display("timeout waiting for the pipeline to drain");
            errors++;
        end
        errors += mem_wb_top_i.mem_wb_checker_i.assert_failures;
        $display("run complete with %0d errors", errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/mips_mem_pkg.sv
design/ex_mem_stage.sv
design/data_memory.sv
design/mem_wb_stage.sv
design/mem_wb_top.sv
dv/mem_wb_checker.sv
dv/tb_mem_wb.sv

// ==== Bender.yml ====
package:
  name: mips_mem_wb

sources:
  - design/mips_mem_pkg.sv
  - design/ex_mem_stage.sv
  - design/data_memory.sv
  - design/mem_wb_stage.sv
  - design/mem_wb_top.sv
  - target: test
    files:
      - dv/mem_wb_checker.sv
      - dv/tb_mem_wb.sv
